/* logic/lcd_ctrl_pkg.sv */
package lcd_ctrl_pkg;

    // Host operation codes, as seen on the operation input
    typedef enum logic [1:0] {
        OP_NONE  = 2'b00,
        OP_DATA  = 2'b01, // Character write, RS high
        OP_INSTR = 2'b10, // Instruction write, RS low
        OP_CLEAR = 2'b11
    } op_t;

    // What the nibble writer does with one transfer
    typedef enum logic [1:0] {
        XFER_WAIT   = 2'b00, // Delay only, E stays low
        XFER_NIBBLE = 2'b01, // High nibble only
        XFER_BYTE   = 2'b10  // High nibble then low nibble
    } xfer_kind_t;

    typedef logic [3:0] nibble_t;   // LCD data bus DB7..DB4
    typedef logic [7:0] lcd_byte_t; // Command or character code

    // Delay counter width, covers the longest wait at 24 MHz
    localparam int TIMER_W = 20;

    // Power-up nibble, only bits 7:4 reach the bus
    localparam lcd_byte_t CMD_INIT = 8'h30;

    // 4-bit bus, 2 lines, 5x8 font
    localparam lcd_byte_t CMD_FUNCTION_SET = 8'h28;

    // Display on, cursor and blink off
    localparam lcd_byte_t CMD_DISPLAY_ON = 8'h0C;

    // Cursor moves right, no display shift
    localparam lcd_byte_t CMD_ENTRY_MODE = 8'h06;

    // Clear DDRAM and home the cursor
    localparam lcd_byte_t CMD_CLEAR = 8'h01;

endpackage

/* logic/lcd_req_if.sv */
interface lcd_req_if;
    import lcd_ctrl_pkg::*;

    logic      valid;     // Request pending
    op_t       op;
    lcd_byte_t data_byte; // Held stable while valid
    logic      done;      // One-cycle pulse, settle wait included

    modport owner (
        output valid, op, data_byte,
        input  done
    );

    modport user (
        input  valid, op, data_byte,
        output done
    );

endinterface

/* logic/lcd_xfer_if.sv */
interface lcd_xfer_if;
    import lcd_ctrl_pkg::*;

    logic               req;         // Single-cycle strobe while busy is low
    xfer_kind_t         kind;
    logic               rs;
    lcd_byte_t          data_byte;
    logic [TIMER_W-1:0] wait_cycles; // Settle time after the last nibble
    logic               busy;
    logic               done;        // Pulses as busy falls

    modport master (
        output req, kind, rs, data_byte, wait_cycles,
        input  busy, done
    );

    modport slave (
        input  req, kind, rs, data_byte, wait_cycles,
        output busy, done
    );

endinterface

/* logic/lcd_request_reg.sv */
module lcd_request_reg (
    input  logic                    clk,
    input  logic                    flag_reset,
    input  logic                    start,
    input  lcd_ctrl_pkg::op_t       operation,
    input  lcd_ctrl_pkg::lcd_byte_t data_in,
    input  logic                    init_done,
    output logic                    ready,
    lcd_req_if.owner                req
);
    import lcd_ctrl_pkg::*;

    logic pending;
    logic accept;

    // Host may only start once init is over and nothing is queued
    assign ready  = init_done && !pending;
    assign accept = start && ready && (operation != OP_NONE); // OP_NONE never latches

    assign req.valid = pending;

    always_ff @(posedge clk) begin
        if (flag_reset) begin
            pending <= 1'b0;
        end else if (req.done) begin
            pending <= 1'b0; // Ready returns next cycle
        end else if (accept) begin
            pending <= 1'b1;
        end
    end

    // Copy of the request, so the host inputs are free after acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            req.op        <= operation;
            req.data_byte <= data_in;
        end
    end

endmodule

/* logic/lcd_sequencer.sv */
module lcd_sequencer #(
    parameter int unsigned T_POWER_UP = 36000,
    parameter int unsigned T_INIT1    = 98400,
    parameter int unsigned T_INIT2    = 2400,
    parameter int unsigned T_INIT3    = 1008,
    parameter int unsigned T_CMD      = 2400,
    parameter int unsigned T_CLEAR    = 39360
) (
    input  logic       clk,
    input  logic       flag_reset,
    output logic       init_done,
    lcd_req_if.user    req,
    lcd_xfer_if.master xfer
);
    import lcd_ctrl_pkg::*;

    // Power-up script runs S_POWER to S_CLEAR in order
    typedef enum logic [3:0] {
        S_POWER,
        S_INIT1,
        S_INIT2,
        S_INIT3,
        S_FUNC,
        S_DISPLAY,
        S_ENTRY,
        S_CLEAR,
        S_IDLE,
        S_HOST
    } state_t;

    state_t state;
    logic   in_flight; // Current step handed to the writer

    // Transfer fields for the step in progress
    always_comb begin
        xfer.kind        = XFER_BYTE;
        xfer.rs          = 1'b0;
        xfer.data_byte   = CMD_CLEAR;
        xfer.wait_cycles = TIMER_W'(T_CMD);
        case (state)
            S_POWER: begin
                xfer.kind        = XFER_WAIT;
                xfer.wait_cycles = TIMER_W'(T_POWER_UP);
            end
            S_INIT1: begin
                xfer.kind        = XFER_NIBBLE;
                xfer.data_byte   = CMD_INIT;
                xfer.wait_cycles = TIMER_W'(T_INIT1);
            end
            S_INIT2: begin
                xfer.kind        = XFER_NIBBLE;
                xfer.data_byte   = CMD_INIT;
                xfer.wait_cycles = TIMER_W'(T_INIT2);
            end
            S_INIT3: begin
                xfer.kind        = XFER_NIBBLE;
                xfer.data_byte   = CMD_INIT;
                xfer.wait_cycles = TIMER_W'(T_INIT3);
            end
            S_FUNC:    xfer.data_byte = CMD_FUNCTION_SET;
            S_DISPLAY: xfer.data_byte = CMD_DISPLAY_ON;
            S_ENTRY:   xfer.data_byte = CMD_ENTRY_MODE;
            S_CLEAR:   xfer.wait_cycles = TIMER_W'(T_CLEAR);
            S_HOST: begin
                case (req.op)
                    OP_DATA: begin
                        xfer.rs        = 1'b1;
                        xfer.data_byte = req.data_byte;
                    end
                    OP_INSTR: xfer.data_byte = req.data_byte;
                    default:  xfer.wait_cycles = TIMER_W'(T_CLEAR); // Clear, OP_NONE never gets here
                endcase
            end
            default: ;
        endcase
    end

    // One strobe per step, only while the writer is free
    assign xfer.req = (state != S_IDLE) && !in_flight && !xfer.busy;

    assign req.done = (state == S_HOST) && xfer.done;

    always_ff @(posedge clk) begin
        if (flag_reset) begin
            state     <= S_POWER;
            in_flight <= 1'b0;
            init_done <= 1'b0;
        end else begin
            if (xfer.req) begin
                in_flight <= 1'b1;
            end
            if (xfer.done) begin
                in_flight <= 1'b0;
                case (state)
                    S_CLEAR: begin
                        state     <= S_IDLE;
                        init_done <= 1'b1; // Stays set until the next reset
                    end
                    S_HOST:  state <= S_IDLE;
                    default: state <= state_t'(state + 4'd1); // Next script step
                endcase
            end
            if ((state == S_IDLE) && req.valid) begin
                state <= S_HOST;
            end
        end
    end

endmodule

/* logic/lcd_nibble_writer.sv */
module lcd_nibble_writer #(
    parameter int unsigned E_PULSE = 6
) (
    input  logic                  clk,
    input  logic                  flag_reset,
    lcd_xfer_if.slave             xfer,
    output lcd_ctrl_pkg::nibble_t lcd_data,
    output logic                  lcd_rs,
    output logic                  lcd_e
);
    import lcd_ctrl_pkg::*;

    typedef enum logic [1:0] {
        PH_E_HIGH, // First nibble, E high
        PH_E_LOW,  // Gap between the two nibbles
        PH_SECOND, // Low nibble, E high
        PH_SETTLE  // E low gap plus command wait
    } phase_t;

    localparam logic [TIMER_W-1:0] E_LAST = TIMER_W'(E_PULSE - 1);

    phase_t             phase;
    logic [TIMER_W-1:0] count;    // The single delay down-counter
    logic               is_byte;
    nibble_t            low_nib;
    logic [TIMER_W-1:0] wait_q;
    logic [TIMER_W-1:0] settle_last;

    // E low for one pulse width, then the command wait
    assign settle_last = TIMER_W'(E_PULSE) + wait_q - 1'b1;

    always_ff @(posedge clk) begin
        if (flag_reset) begin
            phase     <= PH_SETTLE;
            count     <= '0;
            xfer.busy <= 1'b0;
            xfer.done <= 1'b0;
            lcd_e     <= 1'b0;
            lcd_rs    <= 1'b0;
            lcd_data  <= '0;
        end else begin
            xfer.done <= 1'b0;
            if (!xfer.busy) begin
                if (xfer.req) begin
                    xfer.busy <= 1'b1;
                    if (xfer.kind == XFER_WAIT) begin
                        phase <= PH_SETTLE;
                        count <= xfer.wait_cycles - 1'b1; // Pins keep their values
                    end else begin
                        phase    <= PH_E_HIGH;
                        count    <= E_LAST;
                        lcd_e    <= 1'b1;
                        lcd_data <= xfer.data_byte[7:4]; // High nibble goes first
                        lcd_rs   <= xfer.rs;
                    end
                end
            end else if (count != '0) begin
                count <= count - 1'b1;
            end else begin
                case (phase)
                    PH_E_HIGH: begin
                        lcd_e <= 1'b0;
                        if (is_byte) begin
                            phase <= PH_E_LOW;
                            count <= E_LAST;
                        end else begin
                            phase <= PH_SETTLE;
                            count <= settle_last;
                        end
                    end
                    PH_E_LOW: begin
                        lcd_e    <= 1'b1;
                        lcd_data <= low_nib;
                        phase    <= PH_SECOND;
                        count    <= E_LAST;
                    end
                    PH_SECOND: begin
                        lcd_e <= 1'b0;
                        phase <= PH_SETTLE;
                        count <= settle_last;
                    end
                    PH_SETTLE: begin
                        xfer.busy <= 1'b0; // Free again as done pulses
                        xfer.done <= 1'b1;
                    end
                endcase
            end
        end
    end

    // Transfer details kept for the later phases
    always_ff @(posedge clk) begin
        if (!xfer.busy && xfer.req) begin
            is_byte <= (xfer.kind == XFER_BYTE);
            low_nib <= xfer.data_byte[3:0];
            wait_q  <= xfer.wait_cycles;
        end
    end

endmodule

/* logic/lcd_top.sv */
module lcd_top #(
    parameter int unsigned E_PULSE    = 6,
    parameter int unsigned T_POWER_UP = 36000,
    parameter int unsigned T_INIT1    = 98400,
    parameter int unsigned T_INIT2    = 2400,
    parameter int unsigned T_INIT3    = 1008,
    parameter int unsigned T_CMD      = 2400,
    parameter int unsigned T_CLEAR    = 39360
) (
    input  logic                    clk,
    input  logic                    flag_reset,
    input  logic                    start,
    input  lcd_ctrl_pkg::op_t       operation,
    input  lcd_ctrl_pkg::lcd_byte_t data_in,
    output logic                    ready,
    output lcd_ctrl_pkg::nibble_t   lcd_data,
    output logic                    lcd_rs,
    output logic                    lcd_e
);

    logic init_done; // Power-up script finished

    lcd_req_if  req_bus ();
    lcd_xfer_if xfer_bus ();

    // Host side, holds one request at a time
    lcd_request_reg u_request_reg (
        .clk        (clk),
        .flag_reset (flag_reset),
        .start      (start),
        .operation  (operation),
        .data_in    (data_in),
        .init_done  (init_done),
        .ready      (ready),
        .req        (req_bus.owner)
    );

    lcd_sequencer #(
        .T_POWER_UP (T_POWER_UP),
        .T_INIT1    (T_INIT1),
        .T_INIT2    (T_INIT2),
        .T_INIT3    (T_INIT3),
        .T_CMD      (T_CMD),
        .T_CLEAR    (T_CLEAR)
    ) u_sequencer (
        .clk        (clk),
        .flag_reset (flag_reset),
        .init_done  (init_done),
        .req        (req_bus.user),
        .xfer       (xfer_bus.master)
    );

    // Drives the LCD pins
    lcd_nibble_writer #(
        .E_PULSE (E_PULSE)
    ) u_nibble_writer (
        .clk        (clk),
        .flag_reset (flag_reset),
        .xfer       (xfer_bus.slave),
        .lcd_data   (lcd_data),
        .lcd_rs     (lcd_rs),
        .lcd_e      (lcd_e)
    );

endmodule

/* verif/lcd_bus_monitor.sv */
module lcd_bus_monitor #(
    parameter int E_PULSE = 6,
    parameter int T_CMD   = 2400,
    parameter int T_CLEAR = 39360
) (
    input  logic                    clk,
    input  logic                    flag_reset,
    input  logic                    lcd_e,
    input  lcd_ctrl_pkg::nibble_t   lcd_data,
    input  logic                    lcd_rs,
    input  logic                    ready,
    input  logic                    push,      // Model entry, one cycle after acceptance
    input  lcd_ctrl_pkg::op_t       push_op,
    input  logic                    push_rs,
    input  lcd_ctrl_pkg::lcd_byte_t push_byte,
    output int                      n_init,
    output int                      n_data,
    output int                      n_instr,
    output int                      n_pulses,
    output int                      q_count,
    output int                      err_init,
    output int                      err_data,
    output int                      err_instr,
    output int                      err_stray,
    output int                      err_timing
);
    import lcd_ctrl_pkg::*;

    // Bytes after the three init nibbles, all with RS low
    lcd_byte_t   init_seq [4] = '{8'h28, 8'h0C, 8'h06, 8'h01};
    logic [10:0] exp_q [$]; // {op, rs, byte}
    logic [10:0] entry;
    logic        e_prev;
    logic        held_bad;
    logic        ready_up;
    logic        second;    // Next fall completes a byte
    logic        rise_rs;
    logic        first_rs;
    nibble_t     rise_data;
    nibble_t     first_nib;
    lcd_byte_t   got;
    int          high_cnt;
    int          gap_cnt;
    int          gap_need;  // Minimum E low cycles before the next rise

    function automatic bit compare_byte(input string what, input lcd_byte_t exp_b,
                                        input logic exp_rs, input lcd_byte_t got_b,
                                        input logic rs_hi, input logic rs_lo);
        if (got_b !== exp_b || rs_hi !== exp_rs || rs_lo !== exp_rs) begin
            $display("mismatch at time %0t: %s expected %02h rs %0b, got %02h rs %0b/%0b",
                     $time, what, exp_b, exp_rs, got_b, rs_hi, rs_lo);
            return 1'b1;
        end
        return 1'b0;
    endfunction

    // Pair nibbles into bytes, the first three are lone init nibbles
    task collect_nibble(input nibble_t nib, input logic rs);
        if (n_init < 3) begin
            if (nib !== 4'h3 || rs !== 1'b0) begin
                $display("mismatch at time %0t: init nibble %0d expected 3 rs 0, got %h rs %0b",
                         $time, n_init, nib, rs);
                err_init++;
            end
            n_init++;
        end else if (!second) begin
            first_nib = nib;
            first_rs  = rs;
            second    = 1'b1;
        end else begin
            second = 1'b0;
            got    = {first_nib, nib};
            if (n_init < 7) begin
                err_init += compare_byte("power-up byte", init_seq[n_init-3], 1'b0,
                                         got, first_rs, rs);
                gap_need = E_PULSE + ((n_init == 6) ? T_CLEAR : T_CMD);
                n_init++;
                if (n_init == 7) begin
                    $display("power_up       checked %0d, errors %0d", n_init, err_init);
                end
            end else if (exp_q.size() == 0) begin
                $display("Byte %02h went out on the bus with no request outstanding", got);
                err_stray++;
            end else begin
                entry    = exp_q.pop_front();
                gap_need = E_PULSE + ((op_t'(entry[10:9]) == OP_CLEAR) ? T_CLEAR : T_CMD);
                if (op_t'(entry[10:9]) == OP_DATA) begin
                    n_data++;
                    err_data += compare_byte("data write", entry[7:0], entry[8],
                                             got, first_rs, rs);
                end else begin
                    n_instr++; // Clear requests count here too
                    err_instr += compare_byte("instruction write", entry[7:0], entry[8],
                                              got, first_rs, rs);
                end
            end
        end
    endtask

    always @(posedge clk) begin
        if (flag_reset) begin
            exp_q.delete();
            {n_init, n_data, n_instr, n_pulses, q_count} = '0;
            {err_init, err_data, err_instr, err_stray, err_timing} = '0;
            {e_prev, held_bad, ready_up, second} = '0;
            high_cnt = 0;
            gap_cnt  = 0;
            gap_need = 0;
        end else begin
            if (push) begin
                exp_q.push_back({push_op, push_rs, push_byte});
            end
            if (ready && !ready_up && n_init < 7) begin
                $display("mismatch at time %0t: ready rose before power-up ended", $time);
                err_init++;
            end
            ready_up = ready_up | ready;
            if (lcd_e && !e_prev) begin
                n_pulses++;
                high_cnt  = 1;
                rise_data = lcd_data;
                rise_rs   = lcd_rs;
                held_bad  = 1'b0;
                if (gap_cnt < gap_need) begin
                    $display("mismatch at time %0t: E low for %0d cycles, at least %0d needed",
                             $time, gap_cnt, gap_need);
                    err_timing++;
                end
                gap_need = 0;
            end else if (lcd_e) begin
                high_cnt++;
                if (!held_bad && (lcd_data !== rise_data || lcd_rs !== rise_rs)) begin
                    $display("mismatch at time %0t: data or RS moved while E was high", $time);
                    err_timing++;
                    held_bad = 1'b1;
                end
            end else if (e_prev) begin
                if (high_cnt != E_PULSE) begin
                    $display("mismatch at time %0t: E high for %0d cycles, expected %0d",
                             $time, high_cnt, E_PULSE);
                    err_timing++;
                end
                gap_cnt = 1;
                collect_nibble(rise_data, rise_rs);
            end else begin
                gap_cnt++;
            end
            e_prev  = lcd_e;
            q_count = exp_q.size();
        end
    end

endmodule

/* verif/tb_lcd_top.sv */
module tb_lcd_top;
    import lcd_ctrl_pkg::*;

    localparam int E_PULSE      = 2;
    localparam int T_POWER_UP   = 40;
    localparam int T_INIT1      = 20;
    localparam int T_INIT2      = 10;
    localparam int T_INIT3      = 8;
    localparam int T_CMD        = 12;
    localparam int T_CLEAR      = 30;
    localparam int HALF_PERIOD  = 4;
    localparam int RESET_CYCLES = 8;
    localparam int N_SLOTS      = 60;
    localparam int GAP_MAX      = 6;
    localparam int INIT_PULSES  = 11; // Three init nibbles and four bytes
    localparam int INIT_CYCLES  = T_POWER_UP + T_INIT1 + T_INIT2 + T_INIT3 + 3 * T_CMD
                                  + T_CLEAR + 7 * 4 * E_PULSE;
    localparam int LIMIT_CYCLES = 2 * (RESET_CYCLES + INIT_CYCLES
                                  + N_SLOTS * (4 * E_PULSE + T_CLEAR + GAP_MAX));

    logic        clk;
    logic        flag_reset;
    logic        start;
    op_t         operation;
    lcd_byte_t   data_in;
    logic        ready;
    nibble_t     lcd_data;
    logic        lcd_rs;
    logic        lcd_e;
    logic        push;
    op_t         push_op;
    logic        push_rs;
    lcd_byte_t   push_byte;
    int          accepted;
    int          starts;
    int          n_init, n_data, n_instr, n_pulses, q_count;
    int          err_init, err_data, err_instr, err_stray, err_timing;
    int          err_pu, err_ignored, fails, errors, gap;
    integer      seed;
    logic [31:0] r;

    lcd_top #(
        .E_PULSE (E_PULSE), .T_POWER_UP (T_POWER_UP), .T_INIT1 (T_INIT1),
        .T_INIT2 (T_INIT2), .T_INIT3 (T_INIT3), .T_CMD (T_CMD), .T_CLEAR (T_CLEAR)
    ) uut (
        .clk (clk), .flag_reset (flag_reset), .start (start), .operation (operation),
        .data_in (data_in), .ready (ready), .lcd_data (lcd_data), .lcd_rs (lcd_rs),
        .lcd_e (lcd_e)
    );

    lcd_bus_monitor #(.E_PULSE (E_PULSE), .T_CMD (T_CMD), .T_CLEAR (T_CLEAR)) bus_check (
        .clk (clk), .flag_reset (flag_reset), .lcd_e (lcd_e), .lcd_data (lcd_data),
        .lcd_rs (lcd_rs), .ready (ready), .push (push), .push_op (push_op),
        .push_rs (push_rs), .push_byte (push_byte), .n_init (n_init), .n_data (n_data),
        .n_instr (n_instr), .n_pulses (n_pulses), .q_count (q_count), .err_init (err_init),
        .err_data (err_data), .err_instr (err_instr), .err_stray (err_stray),
        .err_timing (err_timing)
    );

    always #HALF_PERIOD clk = ~clk;

    // Reference model uses the same acceptance rule as the host handshake
    always @(posedge clk) begin
        push <= 1'b0;
        if (flag_reset) begin
            accepted <= 0;
            starts   <= 0;
        end else if (start) begin
            starts <= starts + 1;
            if (ready && operation != OP_NONE) begin
                push      <= 1'b1;
                push_op   <= operation;
                push_rs   <= (operation == OP_DATA);
                push_byte <= (operation == OP_CLEAR) ? 8'h01 : data_in; // data_in unused on clear
                accepted  <= accepted + 1;
            end
        end
    end

    initial begin
        seed       = 87;
        clk        = 1'b0;
        flag_reset = 1'b1;
        start      = 1'b0;
        operation  = OP_NONE;
        data_in    = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        flag_reset <= 1'b0;
        for (int slot = 0; slot < N_SLOTS; slot++) begin
            gap = $unsigned($random(seed)) % (GAP_MAX + 1);
            repeat (gap) begin
                @(posedge clk);
                r = $random(seed);
                start     <= 1'b0;
                operation <= op_t'(r[1:0]); // Inputs wander while a request is held
                data_in   <= r[9:2];
            end
            r = $random(seed);
            @(posedge clk);
            if (r[13:12] != 2'b00) begin
                while (!ready) @(posedge clk);
            end
            start     <= 1'b1; // Otherwise may land while ready is low
            operation <= op_t'(r[1:0]);
            data_in   <= r[9:2];
            @(posedge clk);
            start <= 1'b0;
        end
        @(posedge clk);
        while (!ready) @(posedge clk);
        @(negedge clk);
        err_pu      = err_init + (n_init != 7);
        err_ignored = err_stray;
        if (q_count != 0) begin
            $display("%0d requested bytes never went out on the bus", q_count);
            err_ignored++;
        end
        if (n_pulses != INIT_PULSES + 2 * accepted) begin
            $display("mismatch at time %0t: E pulsed %0d times, %0d expected",
                     $time, n_pulses, INIT_PULSES + 2 * accepted);
            err_ignored++;
        end
        $display("data_writes    checked %0d, errors %0d", n_data, err_data);
        $display("instr_writes   checked %0d, errors %0d", n_instr, err_instr);
        $display("ignored_starts checked %0d, errors %0d", starts - accepted, err_ignored);
        $display("bus_timing     checked %0d, errors %0d", n_pulses, err_timing);
        fails  = (err_pu != 0) + (err_data != 0) + (err_instr != 0) + (err_ignored != 0)
                 + (err_timing != 0);
        errors = err_pu + err_data + err_instr + err_ignored + err_timing;
        $display("tests 5, passed %0d, failed %0d, errors %0d", 5 - fails, fails, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(LIMIT_CYCLES * 2 * HALF_PERIOD);
        $display("Run did not finish within %0d cycles, stopped by the watchdog", LIMIT_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

endmodule

/* compile.f */
logic/lcd_ctrl_pkg.sv
logic/lcd_req_if.sv
logic/lcd_xfer_if.sv
logic/lcd_request_reg.sv
logic/lcd_sequencer.sv
logic/lcd_nibble_writer.sv
logic/lcd_top.sv
verif/lcd_bus_monitor.sv
verif/tb_lcd_top.sv

/* Bender.yml */
package:
  name: lcd_ctrl

sources:
  - files:
      - logic/lcd_ctrl_pkg.sv
      - logic/lcd_req_if.sv
      - logic/lcd_xfer_if.sv
      - logic/lcd_request_reg.sv
      - logic/lcd_sequencer.sv
      - logic/lcd_nibble_writer.sv
      - logic/lcd_top.sv
  - target: simulation
    files:
      - verif/lcd_bus_monitor.sv
      - verif/tb_lcd_top.sv
